// ==== source/memory_game_pkg.sv ====
// Card, score, countdown and segment types, pair table, digit codes, FSM states
`default_nettype none

package memory_game_pkg;

	localparam int CARD_COUNT = 18; // One switch per card
	localparam int PAIR_COUNT = 9; // Fixed pairs among the cards

	typedef logic [CARD_COUNT-1:0] card_set_t; // One bit per card
	typedef logic [4:0] card_index_t; // Number of a single card
	typedef logic [3:0] score_t; // One decimal digit
	typedef logic [7:0] countdown_t; // Seconds left, shown as two hex digits
	typedef logic [3:0] digit_code_t; // Decoder input, 0-9 plus glyphs
	typedef logic [6:0] segments_t; // Active low, bit 0 is segment a
	typedef logic player_t; // 0 is player 1, 1 is player 2

	// One press and release per phase
	typedef enum logic [2:0] {
		choose_first,
		first_held,
		choose_second,
		second_held,
		check,
		check_held
	} turn_state_t;

	// Pair i is the two cards pair_first[i] and pair_second[i]
	localparam card_index_t pair_first [PAIR_COUNT] = '{
		5'd17, 5'd16, 5'd15, 5'd14, 5'd13, 5'd12, 5'd9, 5'd8, 5'd6
	};
	localparam card_index_t pair_second [PAIR_COUNT] = '{
		5'd10, 5'd0, 5'd4, 5'd3, 5'd2, 5'd11, 5'd7, 5'd5, 5'd1
	};

	localparam digit_code_t CODE_P = 4'd10; // Player tag glyph
	localparam digit_code_t CODE_BLANK = 4'd11; // All segments off
	localparam score_t SCORE_WRAP = 4'd9; // Last value before wrap to 0
	localparam countdown_t COUNTDOWN_START = 8'd255; // Reload value

endpackage

`default_nettype wire

// ==== source/turn_controller.sv ====
// Turn controller FSM: key-stepped phases, capture levels and check strobe
`timescale 1ns/10ps
`default_nettype none

module turn_controller
(
	input  logic clock,
	input  logic reset_n,
	input  logic key_step, // Active low step key
	output logic capture_first, // Load first card while high
	output logic capture_second, // Load second card while high
	output logic check_strobe // One cycle on entry to check
);

	memory_game_pkg::turn_state_t state, next_state;
	logic pressed;

	assign pressed = ~key_step; // Key pulls low when pressed

	always_comb
	begin
		next_state = state; // Hold by default
		case (state)
			memory_game_pkg::choose_first:
				if (pressed) next_state = memory_game_pkg::first_held;
			memory_game_pkg::first_held:
				if (!pressed) next_state = memory_game_pkg::choose_second; // On release
			memory_game_pkg::choose_second:
				if (pressed) next_state = memory_game_pkg::second_held;
			memory_game_pkg::second_held:
				if (!pressed) next_state = memory_game_pkg::check;
			memory_game_pkg::check:
				if (pressed) next_state = memory_game_pkg::check_held;
			memory_game_pkg::check_held:
				if (!pressed) next_state = memory_game_pkg::choose_first; // Back to start
			default:
				next_state = memory_game_pkg::choose_first; // Recover from bad encoding
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			state <= memory_game_pkg::choose_first;
			check_strobe <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// Registered so it lines up with the first cycle in check
			check_strobe <= (state == memory_game_pkg::second_held)
				&& (next_state == memory_game_pkg::check);
		end
	end

	assign capture_first = (state == memory_game_pkg::choose_first)
		|| (state == memory_game_pkg::first_held);
	assign capture_second = (state == memory_game_pkg::choose_second)
		|| (state == memory_game_pkg::second_held);

endmodule

`default_nettype wire

// ==== source/pair_checker.sv ====
// Pair checker: card capture, pair table match, score strobe and turn tracking
`timescale 1ns/10ps
`default_nettype none

module pair_checker
(
	input  logic clock,
	input  logic reset_n,
	input  memory_game_pkg::card_set_t switches, // Raw card switches
	input  logic capture_first,
	input  logic capture_second,
	input  logic check_strobe,
	output logic score_strobe, // One cycle after check_strobe on a match
	output memory_game_pkg::player_t scoring_player, // Who matched
	output memory_game_pkg::player_t player, // Whose turn it is
	output logic match_led // Last check was a match
);

	memory_game_pkg::card_set_t first_card; // Held first selection
	memory_game_pkg::card_set_t second_card; // Held second selection
	logic pair_hit;
	logic both_chosen;

	// Card registers follow the switches while their phase is open
	always_ff @(posedge clock)
	begin
		if (capture_first)
			first_card <= switches;
		if (capture_second)
			second_card <= switches;
	end

	// Any table pair present, either card picked first
	always_comb
	begin
		pair_hit = 1'b0;
		for (int i = 0; i < memory_game_pkg::PAIR_COUNT; i++)
		begin
			if ((first_card[memory_game_pkg::pair_first[i]]
					&& second_card[memory_game_pkg::pair_second[i]])
				|| (first_card[memory_game_pkg::pair_second[i]]
					&& second_card[memory_game_pkg::pair_first[i]]))
				pair_hit = 1'b1;
		end
	end

	assign both_chosen = (|first_card) && (|second_card); // Neither selection empty

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			score_strobe <= 1'b0;
			scoring_player <= 1'b0;
			player <= 1'b0; // Player 1 starts
			match_led <= 1'b0;
		end
		else
		begin
			score_strobe <= check_strobe && pair_hit; // Single pulse per check
			if (check_strobe)
			begin
				match_led <= pair_hit; // Held until the next check
				if (pair_hit)
					scoring_player <= player; // Matcher keeps the turn
				else if (both_chosen)
					player <= ~player; // Miss passes the turn
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/score_keeper.sv ====
// Score keeper: two wrapping decimal score counters and the leader compare
`timescale 1ns/10ps
`default_nettype none

module score_keeper
(
	input  logic clock,
	input  logic reset_n,
	input  logic score_strobe, // One pulse per match
	input  memory_game_pkg::player_t scoring_player,
	output memory_game_pkg::score_t score_p1,
	output memory_game_pkg::score_t score_p2,
	output memory_game_pkg::digit_code_t leader // 1, 2 or 0 for a tie
);

	memory_game_pkg::score_t scores [2]; // Indexed by player

	// Each counter only steps on its own player's strobe
	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			scores[0] <= '0;
			scores[1] <= '0;
		end
		else if (score_strobe)
		begin
			for (int p = 0; p < 2; p++)
			begin
				if (scoring_player == memory_game_pkg::player_t'(p))
				begin
					if (scores[p] == memory_game_pkg::SCORE_WRAP)
						scores[p] <= '0; // 9 wraps to 0
					else
						scores[p] <= scores[p] + 4'd1;
				end
			end
		end
	end

	assign score_p1 = scores[0];
	assign score_p2 = scores[1];

	// Leader follows the shown digits, so a wrap can change it
	always_comb
	begin
		if (scores[0] > scores[1])
			leader = 4'd1;
		else if (scores[1] > scores[0])
			leader = 4'd2;
		else
			leader = 4'd0; // Tie
	end

endmodule

`default_nettype wire

// ==== source/round_timer.sv ====
// Round timer: seconds divider, 8-bit countdown and blink phase
`timescale 1ns/10ps
`default_nettype none

module round_timer
#(
	parameter int TICK_CYCLES = 50_000_000 // Clock cycles per second
)
(
	input  logic clock,
	input  logic reset_n,
	output memory_game_pkg::countdown_t countdown, // Seconds left
	output logic blink // Toggles every second
);

	localparam int DIV_WIDTH = $clog2(TICK_CYCLES + 1);
	localparam logic [DIV_WIDTH-1:0] DIV_RELOAD = DIV_WIDTH'(TICK_CYCLES - 1);

	logic [DIV_WIDTH-1:0] divider; // Counts down to the next tick
	logic tick;

	assign tick = (divider == '0); // Last cycle of each second

	always_ff @(posedge clock)
	begin
		if (!reset_n)
			divider <= DIV_RELOAD;
		else if (tick)
			divider <= DIV_RELOAD; // Start the next second
		else
			divider <= divider - 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			countdown <= memory_game_pkg::COUNTDOWN_START;
			blink <= 1'b0; // Tag and leader visible first
		end
		else if (tick)
		begin
			blink <= ~blink;
			if (countdown == '0)
				countdown <= memory_game_pkg::COUNTDOWN_START; // Roll over to FF
			else
				countdown <= countdown - 8'd1;
		end
	end

endmodule

`default_nettype wire

// ==== source/seven_seg_display.sv ====
// Seven-segment decoder with digit, P and blank glyphs
`timescale 1ns/10ps
`default_nettype none

module seven_seg_display
(
	input  memory_game_pkg::digit_code_t code,
	output memory_game_pkg::segments_t segments // Active low, gfedcba
);

	always_comb
	begin
		case (code)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0011000;
			4'hA: segments = 7'b0001100; // P
			4'hB: segments = 7'b1111111; // Blank
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001; // Lower case d
			4'hE: segments = 7'b0000110;
			4'hF: segments = 7'b0001110;
			default: segments = 7'b1111111; // Unknown input stays dark
		endcase
	end

endmodule

`default_nettype wire

// ==== source/memory_game.sv ====
// Memory game top level: controller, checker, scores, timer and six digit decoders
`timescale 1ns/10ps
`default_nettype none

module memory_game
#(
	parameter int TICK_CYCLES = 50_000_000 // Clock cycles per second
)
(
	input  logic clock,
	input  logic reset_n,
	input  memory_game_pkg::card_set_t switches,
	input  logic key_step, // Active low
	output memory_game_pkg::segments_t hex_p1_score,
	output memory_game_pkg::segments_t hex_p2_score,
	output memory_game_pkg::segments_t hex_timer_lo,
	output memory_game_pkg::segments_t hex_timer_hi,
	output memory_game_pkg::segments_t hex_player_tag,
	output memory_game_pkg::segments_t hex_leader,
	output memory_game_pkg::player_t player,
	output logic match_led
);

	logic capture_first, capture_second, check_strobe;
	logic score_strobe;
	memory_game_pkg::player_t scoring_player;
	memory_game_pkg::score_t score_p1, score_p2;
	memory_game_pkg::digit_code_t leader;
	memory_game_pkg::countdown_t countdown;
	logic blink;
	memory_game_pkg::digit_code_t tag_code, leader_code;

	turn_controller u_turn_controller (
		.clock(clock), .reset_n(reset_n), .key_step(key_step),
		.capture_first(capture_first), .capture_second(capture_second),
		.check_strobe(check_strobe)
	);

	pair_checker u_pair_checker (
		.clock(clock), .reset_n(reset_n), .switches(switches),
		.capture_first(capture_first), .capture_second(capture_second),
		.check_strobe(check_strobe), .score_strobe(score_strobe),
		.scoring_player(scoring_player), .player(player), .match_led(match_led)
	);

	score_keeper u_score_keeper (
		.clock(clock), .reset_n(reset_n), .score_strobe(score_strobe),
		.scoring_player(scoring_player), .score_p1(score_p1), .score_p2(score_p2),
		.leader(leader)
	);

	round_timer #(.TICK_CYCLES(TICK_CYCLES)) u_round_timer (
		.clock(clock), .reset_n(reset_n), .countdown(countdown), .blink(blink)
	);

	// Tag and leader flash together on the blink phase
	assign tag_code = blink ? memory_game_pkg::CODE_BLANK : memory_game_pkg::CODE_P;
	assign leader_code = blink ? memory_game_pkg::CODE_BLANK : leader;

	seven_seg_display u_hex_p1 (.code(score_p1), .segments(hex_p1_score));
	seven_seg_display u_hex_p2 (.code(score_p2), .segments(hex_p2_score));
	seven_seg_display u_hex_timer_lo (.code(countdown[3:0]), .segments(hex_timer_lo));
	seven_seg_display u_hex_timer_hi (.code(countdown[7:4]), .segments(hex_timer_hi));
	seven_seg_display u_hex_tag (.code(tag_code), .segments(hex_player_tag));
	seven_seg_display u_hex_leader (.code(leader_code), .segments(hex_leader));

endmodule

`default_nettype wire

// ==== verification/memory_game_model.svh ====
// LFSR, pair list, segment glyphs, segment decode and leader rule for the testbench
`ifndef MEMORY_GAME_MODEL_SVH
`define MEMORY_GAME_MODEL_SVH

// Taps 16, 14, 13, 11, shifting right
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
endfunction

// One LFSR step per bit taken
function automatic int take_bits(input int count);
	int value;
	value = 0;
	for (int i = 0; i < count; i++)
	begin
		value = (value << 1) | int'(lfsr_state[0]);
		lfsr_state = lfsr_next(lfsr_state);
	end
	return value;
endfunction

// The nine fixed pairs of the game
function automatic int pair_card(input int idx, input bit second);
	int firsts [9] = '{17, 16, 15, 14, 13, 12, 9, 8, 6};
	int seconds [9] = '{10, 0, 4, 3, 2, 11, 7, 5, 1};
	return second ? seconds[idx] : firsts[idx];
endfunction

function automatic bit is_pair(input int a, input int b);
	for (int i = 0; i < 9; i++)
	begin
		if ((pair_card(i, 1'b0) == a && pair_card(i, 1'b1) == b)
			|| (pair_card(i, 1'b1) == a && pair_card(i, 1'b0) == b))
			return 1'b1;
	end
	return 1'b0;
endfunction

// Lit segments per glyph, a to g, then inverted to active low
function automatic logic [6:0] expected_segments(input int code);
	string lit;
	logic [6:0] segs;
	case (code)
		0: lit = "abcdef";
		1: lit = "bc";
		2: lit = "abdeg";
		3: lit = "abcdg";
		4: lit = "bcfg";
		5: lit = "acdfg";
		6: lit = "acdefg";
		7: lit = "abc";
		8: lit = "abcdefg";
		9: lit = "abcfg";
		10: lit = "abefg"; // P
		12: lit = "adef"; // C
		13: lit = "bcdeg"; // d
		14: lit = "adefg"; // E
		15: lit = "aefg"; // F
		default: lit = ""; // Blank
	endcase
	segs = 7'b1111111;
	for (int i = 0; i < lit.len(); i++)
		segs[int'(lit[i]) - 97] = 1'b0;
	return segs;
endfunction

// Code shown by a digit, -1 if no glyph fits
function automatic int segment_value(input logic [6:0] segs);
	for (int c = 0; c < 16; c++)
	begin
		if (expected_segments(c) == segs)
			return c;
	end
	return -1;
endfunction

function automatic int expected_leader(input int p1, input int p2);
	if (p1 > p2)
		return 1;
	else if (p2 > p1)
		return 2;
	return 0; // Tie
endfunction

`endif

// ==== verification/memory_game_tb.sv ====
// Memory game testbench with clock, reset, turn stimulus, timer monitor, watchdog and report
`timescale 1ns/10ps
`default_nettype none

module memory_game_tb;

	localparam int TICK_CYCLES = 8; // Short seconds
	localparam int HOLD_CYCLES = 3; // Key held down per press
	localparam int SETTLE_CYCLES = 4; // After release, before checking
	localparam int TURN_COUNT = 15; // Turns over all game behaviors
	localparam int TICKS_TO_WATCH = 257; // Full lap including 0 to FF
	localparam int WATCHDOG_CYCLES
		= TURN_COUNT * (3 * (HOLD_CYCLES + SETTLE_CYCLES + 1) + TICK_CYCLES + 2)
		+ (TICKS_TO_WATCH + 2) * TICK_CYCLES + 200;

	logic clock;
	logic reset_n;
	memory_game_pkg::card_set_t switches;
	logic key_step;
	memory_game_pkg::segments_t hex_p1_score, hex_p2_score, hex_timer_lo, hex_timer_hi;
	memory_game_pkg::segments_t hex_player_tag, hex_leader;
	memory_game_pkg::player_t player;
	logic match_led;

	logic [15:0] lfsr_state = 16'd11051; // Seed
	int errors = 0;
	int checks = 0;
	int exp_p1 = 0; // Expected scores
	int exp_p2 = 0;
	logic exp_player = 1'b0;
	logic exp_match = 1'b0;
	bit monitor_on = 1'b0; // Timer watching starts after reset
	int timer_value; // Decoded timer digits or -1 when unreadable
	int last_timer = 255;
	int timer_changes = 0;
	logic countdown_odd;
	logic [6:0] seg_p, seg_blank;

	`include "memory_game_model.svh"

	memory_game #(.TICK_CYCLES(TICK_CYCLES)) UUT (
		.clock(clock), .reset_n(reset_n), .switches(switches), .key_step(key_step),
		.hex_p1_score(hex_p1_score), .hex_p2_score(hex_p2_score),
		.hex_timer_lo(hex_timer_lo), .hex_timer_hi(hex_timer_hi),
		.hex_player_tag(hex_player_tag), .hex_leader(hex_leader),
		.player(player), .match_led(match_led)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	assign seg_p = expected_segments(10);
	assign seg_blank = expected_segments(11);

	always_comb
	begin
		if (segment_value(hex_timer_hi) < 0 || segment_value(hex_timer_lo) < 0)
			timer_value = -1;
		else
			timer_value = segment_value(hex_timer_hi) * 16 + segment_value(hex_timer_lo);
		countdown_odd = timer_value[0];
	end

	task automatic report_mismatch(input string message);
		errors++;
		$display("mismatch at %0t ns: %s", $time, message);
	endtask

	task automatic expect_digit(input logic [6:0] shown, input int code, input string name);
		checks++;
		assert (shown == expected_segments(code))
		else report_mismatch($sformatf("%s shows %b, expected code %0d", name, shown, code));
	endtask

	// Blink counts ticks, so the tag is lit on odd countdown values (255 first)
	assert property (@(posedge clock) disable iff (!monitor_on)
		countdown_odd || (hex_player_tag == seg_blank && hex_leader == seg_blank))
	else report_mismatch("tag or leader lit while countdown is even");
	assert property (@(posedge clock) disable iff (!monitor_on)
		!countdown_odd || hex_player_tag == seg_p)
	else report_mismatch("tag not showing P while countdown is odd");

	// Countdown steps checked at each change of the digits
	always @(negedge clock)
	begin
		if (monitor_on)
		begin
			checks++;
			assert (timer_value >= 0) else report_mismatch("timer digits show no hex value");
			if (timer_value != last_timer)
			begin
				checks++;
				assert (timer_value == (last_timer + 255) % 256)
				else report_mismatch($sformatf("timer went from %0d to %0d",
					last_timer, timer_value));
				timer_changes++;
			end
			last_timer = timer_value;
		end
	end

	// Leader value is compared once the blink phase shows it
	task automatic check_game_state();
		int waited;
		waited = 0;
		expect_digit(hex_p1_score, exp_p1, "p1 score");
		expect_digit(hex_p2_score, exp_p2, "p2 score");
		checks++;
		assert (player == exp_player)
		else report_mismatch($sformatf("player is %0d, expected %0d", player, exp_player));
		checks++;
		assert (match_led == exp_match)
		else report_mismatch($sformatf("match_led is %0d, expected %0d", match_led, exp_match));
		if (!countdown_odd)
			expect_digit(hex_leader, 11, "leader"); // Blink phase high
		while (!countdown_odd && waited <= TICK_CYCLES)
		begin
			@(negedge clock);
			waited++;
		end
		expect_digit(hex_leader, expected_leader(exp_p1, exp_p2), "leader");
	endtask

	// One press and release of the step key
	task automatic press_step(input memory_game_pkg::card_set_t cards);
		switches = cards;
		key_step = 1'b0;
		repeat (HOLD_CYCLES) @(negedge clock);
		key_step = 1'b1;
		repeat (SETTLE_CYCLES) @(negedge clock);
	endtask

	// Card -1 leaves that selection empty
	task automatic play_turn(input int first_card, input int second_card);
		memory_game_pkg::card_set_t first_set, second_set;
		first_set = '0;
		second_set = '0;
		if (first_card >= 0)
			first_set[first_card] = 1'b1;
		if (second_card >= 0)
			second_set[second_card] = 1'b1;
		press_step(first_set);
		press_step(second_set);
		press_step('0); // Leave check
		if (first_card >= 0 && second_card >= 0 && is_pair(first_card, second_card))
		begin
			exp_match = 1'b1;
			if (exp_player == 1'b0)
				exp_p1 = (exp_p1 + 1) % 10; // 9 wraps to 0
			else
				exp_p2 = (exp_p2 + 1) % 10;
		end
		else
		begin
			exp_match = 1'b0;
			if (first_card >= 0 && second_card >= 0)
				exp_player = ~exp_player; // Miss hands over the turn
		end
		check_game_state();
	endtask

	task automatic play_random_pair();
		int idx;
		idx = take_bits(4) % 9;
		if (take_bits(1) == 1)
			play_turn(pair_card(idx, 1'b1), pair_card(idx, 1'b0));
		else
			play_turn(pair_card(idx, 1'b0), pair_card(idx, 1'b1));
	endtask

	task automatic play_random_miss();
		int a;
		int b;
		a = take_bits(5) % 18;
		b = take_bits(5) % 18;
		while (a == b || is_pair(a, b))
			b = take_bits(5) % 18;
		play_turn(a, b);
	endtask

	initial
	begin
		switches = '0;
		key_step = 1'b1; // Released
		reset_n = 1'b0;
		repeat (2) @(negedge clock);
		reset_n = 1'b1;
		monitor_on = 1'b1;
		@(negedge clock);
		expect_digit(hex_timer_hi, 15, "timer high");
		expect_digit(hex_timer_lo, 15, "timer low");
		expect_digit(hex_player_tag, 10, "player tag");
		check_game_state(); // Reset values
		play_random_pair(); // Player 1 scores
		play_random_miss(); // Turn to player 2
		play_random_pair();
		play_turn(-1, take_bits(5) % 18); // Empty first
		play_turn(take_bits(5) % 18, -1); // Empty second
		repeat (10) play_random_pair(); // Through 9 and back
		wait (timer_changes >= TICKS_TO_WATCH);
		$display("errors: %0d, checks: %0d, timer changes: %0d", errors, checks, timer_changes);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: run did not finish in %0d cycles, errors: %0d, checks: %0d",
			WATCHDOG_CYCLES, errors, checks);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verification
source/memory_game_pkg.sv
source/turn_controller.sv
source/pair_checker.sv
source/score_keeper.sv
source/round_timer.sv
source/seven_seg_display.sv
source/memory_game.sv
verification/memory_game_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory game testbench with Verilator and run it once.
# The run passes only when its output holds the pass line.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module memory_game_tb -o memory_game_sim &&
./obj_dir/memory_game_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }
